// ==== compile.f ====
design/ucie_phy_pkg.sv
design/phy_event_if.sv
design/phy_event_decoder.sv
design/phy_link_fsm.sv
design/phy_rdi_encoder.sv
design/ucie_phy_ctl.sv
test/ucie_phy_ctl_asserts.sv
test/tb_ucie_phy_ctl.sv

// ==== design/phy_event_decoder.sv ====
`timescale 1ns/100ps

module phy_event_decoder (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  ucie_phy_pkg::rdi_state_e i_lp_state_req,
  input  logic                    i_lp_linkerror,
  input  logic                    i_phy_trainerror,
  input  logic                    i_phy_pl_error,
  input  ucie_phy_pkg::sb_msg_e   i_sb_msg_in,
  input  logic                    i_clear_flags,
  phy_event_if.decoder            o_ev
);
  import ucie_phy_pkg::*;

  logic err_flag_r;
  logic rst_flag_r;

  // Local requests from the adapter
  assign o_ev.err_local      = i_lp_linkerror | i_phy_trainerror;
  assign o_ev.rst_local      = (i_lp_state_req == RDI_LINKRESET);
  assign o_ev.lp_active_req  = (i_lp_state_req == RDI_ACTIVE);
  assign o_ev.lp_retrain_req = (i_lp_state_req == RDI_RETRAIN);

  // Requests from the remote die
  assign o_ev.err_remote     = (i_sb_msg_in == SB_LNKERR_REQ);
  assign o_ev.rst_remote     = (i_sb_msg_in == SB_LNKRST_REQ);
  assign o_ev.retrain_remote = i_phy_pl_error | (i_sb_msg_in == SB_RETRAIN_REQ);

  assign o_ev.sb_msg = i_sb_msg_in;

  // Remember whether error or reset started on this side
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      err_flag_r <= 1'b0;
      rst_flag_r <= 1'b0;
    end else if (i_clear_flags) begin
      err_flag_r <= 1'b0;
      rst_flag_r <= 1'b0;
    end else if (o_ev.err_local) begin
      err_flag_r <= 1'b1;
    end else if (o_ev.rst_local) begin
      rst_flag_r <= 1'b1;
    end
  end

  assign o_ev.err_flag = err_flag_r;
  assign o_ev.rst_flag = rst_flag_r;

endmodule

// ==== design/phy_event_if.sv ====
`timescale 1ns/100ps

interface phy_event_if;
  import ucie_phy_pkg::*;

  logic    err_local;
  logic    err_remote;
  logic    rst_local;
  logic    rst_remote;
  logic    lp_active_req;
  logic    lp_retrain_req;
  logic    retrain_remote;
  sb_msg_e sb_msg;
  logic    err_flag;
  logic    rst_flag;
  // Back signal from the FSM, high in ACTIVE
  logic    clear_flags;

  modport decoder (
    output err_local, err_remote, rst_local, rst_remote,
    output lp_active_req, lp_retrain_req, retrain_remote,
    output sb_msg, err_flag, rst_flag
  );

  modport fsm (
    input err_local, err_remote, rst_local, rst_remote,
    input lp_active_req, lp_retrain_req, retrain_remote,
    input sb_msg, err_flag, rst_flag
  );

endinterface

// ==== design/phy_link_fsm.sv ====
`timescale 1ns/100ps

module phy_link_fsm (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_start_link_training,
  phy_event_if.fsm                i_ev,
  output logic                    o_clear_flags,
  output ucie_phy_pkg::phy_state_e o_state
);
  import ucie_phy_pkg::*;

  phy_state_e       state_r;
  phy_state_e       state_nxt;
  logic [CNT_W-1:0] cnt_r;
  logic             train_done;
  logic             timeout_done;

  // Error exits, items 1 and 2 of the priority
  logic             exit_err_hit;
  phy_state_e       exit_err_nxt;
  // Reset exits, items 3 and 4
  logic             exit_rst_hit;
  phy_state_e       exit_rst_nxt;

  assign train_done   = (cnt_r == CNT_W'(TRAIN_CYCLES - 1));
  assign timeout_done = (cnt_r == CNT_W'(TIMEOUT_CYCLES - 1));

  assign exit_err_hit = i_ev.err_local | i_ev.err_remote;
  assign exit_err_nxt = i_ev.err_local ? LINK_ERR_TX : LINK_ERROR;
  assign exit_rst_hit = i_ev.rst_local | i_ev.rst_remote;
  assign exit_rst_nxt = i_ev.rst_local ? LINK_RST_TX : LINK_RESET;

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      LINK_ERR_TX: begin
        if (i_ev.sb_msg == SB_LNKERR_RSP) begin
          state_nxt = LINK_ERROR;
        end
      end
      LINK_RST_TX: begin
        if (i_ev.sb_msg == SB_LNKERR_RSP) begin
          state_nxt = LINK_ERROR;
        end else if (i_ev.sb_msg == SB_LNKRST_RSP) begin
          state_nxt = LINK_RESET;
        end
      end
      LINK_ERROR: begin
        // Local entry waits for the adapter, remote entry times out
        if (i_ev.err_flag ? i_ev.lp_active_req : timeout_done) begin
          state_nxt = RESET;
        end
      end
      LINK_RESET: begin
        if (exit_err_hit) begin
          state_nxt = exit_err_nxt;
        end else if (i_ev.rst_flag ? i_ev.lp_active_req : timeout_done) begin
          state_nxt = RESET;
        end
      end
      default: begin
        if (exit_err_hit) begin
          state_nxt = exit_err_nxt;
        end else if (exit_rst_hit) begin
          state_nxt = exit_rst_nxt;
        end else begin
          case (state_r)
            RESET: begin
              if (i_start_link_training) begin
                state_nxt = LINK_TRAINING;
              end
            end
            LINK_TRAINING, RETRAIN: begin
              if (train_done) begin
                state_nxt = WAIT_FOR_ADAPTER;
              end
            end
            WAIT_FOR_ADAPTER: begin
              if (i_ev.err_flag || i_ev.rst_flag) begin
                // Recovering from a local error or reset
                if (i_ev.sb_msg == SB_ACT_REQ) begin
                  state_nxt = ACTIVE;
                end
              end else if (i_ev.sb_msg == SB_ACT_REQ) begin
                state_nxt = RSP_ACTIVE;
              end else if (i_ev.lp_active_req) begin
                state_nxt = REQ_ACTIVE;
              end
            end
            REQ_ACTIVE: begin
              if (i_ev.sb_msg == SB_ACT_RSP) begin
                state_nxt = ACTIVE;
              end
            end
            RSP_ACTIVE: begin
              if (i_ev.lp_active_req) begin
                state_nxt = ACTIVE;
              end
            end
            ACTIVE: begin
              if (i_ev.lp_retrain_req) begin
                state_nxt = RETRAIN_TX;
              end else if (i_ev.retrain_remote) begin
                state_nxt = RETRAIN;
              end
            end
            RETRAIN_TX: begin
              if (i_ev.sb_msg == SB_RETRAIN_RSP) begin
                state_nxt = RETRAIN;
              end
            end
            default: begin
              state_nxt = RESET;
            end
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_r <= RESET;
    end else begin
      state_r <= state_nxt;
    end
  end

  // Cycles in the current state, restarts on every change
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt_r <= '0;
    end else if (state_nxt != state_r) begin
      cnt_r <= '0;
    end else if (cnt_r != '1) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  assign o_clear_flags = (state_r == ACTIVE);
  assign o_state       = state_r;

endmodule

// ==== design/phy_rdi_encoder.sv ====
`timescale 1ns/100ps

module phy_rdi_encoder (
  input  ucie_phy_pkg::phy_state_e i_state,
  output ucie_phy_pkg::rdi_state_e o_pl_state_sts,
  output logic                     o_pl_phyinrecenter,
  output logic                     o_pl_inband_pres,
  output logic                     o_rdi_enable,
  output ucie_phy_pkg::sb_msg_e    o_sb_msg_out
);
  import ucie_phy_pkg::*;

  always_comb begin
    // RESET row unless the state says otherwise
    o_pl_state_sts     = RDI_RESET;
    o_pl_phyinrecenter = 1'b0;
    o_pl_inband_pres   = 1'b0;
    o_rdi_enable       = 1'b0;
    o_sb_msg_out       = SB_IDLE;
    case (i_state)
      LINK_TRAINING: begin
        o_pl_phyinrecenter = 1'b1;
      end
      WAIT_FOR_ADAPTER, RSP_ACTIVE: begin
        o_pl_inband_pres = 1'b1;
      end
      REQ_ACTIVE: begin
        o_pl_inband_pres = 1'b1;
        o_sb_msg_out     = SB_ACT_REQ;
      end
      ACTIVE: begin
        o_pl_state_sts   = RDI_ACTIVE;
        o_pl_inband_pres = 1'b1;
        o_rdi_enable     = 1'b1;
        o_sb_msg_out     = SB_ACT_RSP;
      end
      RETRAIN_TX: begin
        o_pl_state_sts   = RDI_ACTIVE;
        o_pl_inband_pres = 1'b1;
        o_rdi_enable     = 1'b1;
        o_sb_msg_out     = SB_RETRAIN_REQ;
      end
      RETRAIN: begin
        o_pl_state_sts     = RDI_RETRAIN;
        o_pl_phyinrecenter = 1'b1;
      end
      // Link still up while the request goes out
      LINK_ERR_TX: begin
        o_pl_state_sts = RDI_ACTIVE;
        o_rdi_enable   = 1'b1;
        o_sb_msg_out   = SB_LNKERR_REQ;
      end
      LINK_RST_TX: begin
        o_pl_state_sts = RDI_ACTIVE;
        o_rdi_enable   = 1'b1;
        o_sb_msg_out   = SB_LNKRST_REQ;
      end
      LINK_RESET: begin
        o_pl_state_sts = RDI_LINKRESET;
        o_sb_msg_out   = SB_LNKRST_RSP;
      end
      LINK_ERROR: begin
        o_pl_state_sts = RDI_LINKERROR;
        o_sb_msg_out   = SB_LNKERR_RSP;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== design/ucie_phy_ctl.sv ====
`timescale 1ns/100ps

module ucie_phy_ctl (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic [3:0] i_lp_state_req,
  input  logic       i_lp_linkerror,
  input  logic [3:0] i_sb_msg_in,
  input  logic       i_start_link_training,
  input  logic       i_phy_trainerror,
  input  logic       i_phy_pl_error,
  output logic [3:0] o_pl_state_sts,
  output logic       o_pl_phyinrecenter,
  output logic       o_pl_inband_pres,
  output logic       o_rdi_enable,
  output logic [3:0] o_sb_msg_out
);
  import ucie_phy_pkg::*;

  phy_state_e state;
  rdi_state_e pl_state_sts;
  sb_msg_e    sb_msg_out;

  phy_event_if ev ();

  // Decode stage
  phy_event_decoder u_decoder (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_lp_state_req   (rdi_state_e'(i_lp_state_req)),
    .i_lp_linkerror   (i_lp_linkerror),
    .i_phy_trainerror (i_phy_trainerror),
    .i_phy_pl_error   (i_phy_pl_error),
    .i_sb_msg_in      (sb_msg_e'(i_sb_msg_in)),
    .i_clear_flags    (ev.clear_flags),
    .o_ev             (ev.decoder)
  );

  // State stage
  phy_link_fsm u_fsm (
    .i_clk                 (i_clk),
    .i_rst_n               (i_rst_n),
    .i_start_link_training (i_start_link_training),
    .i_ev                  (ev.fsm),
    .o_clear_flags         (ev.clear_flags),
    .o_state               (state)
  );

  // Encode stage
  phy_rdi_encoder u_encoder (
    .i_state            (state),
    .o_pl_state_sts     (pl_state_sts),
    .o_pl_phyinrecenter (o_pl_phyinrecenter),
    .o_pl_inband_pres   (o_pl_inband_pres),
    .o_rdi_enable       (o_rdi_enable),
    .o_sb_msg_out       (sb_msg_out)
  );

  assign o_pl_state_sts = pl_state_sts;
  assign o_sb_msg_out   = sb_msg_out;

endmodule

// ==== design/ucie_phy_pkg.sv ====
package ucie_phy_pkg;

  // Link states of the PHY controller
  typedef enum logic [3:0] {
    RESET            = 4'd0,
    LINK_TRAINING    = 4'd1,
    WAIT_FOR_ADAPTER = 4'd2,
    REQ_ACTIVE       = 4'd3,
    RSP_ACTIVE       = 4'd4,
    ACTIVE           = 4'd5,
    RETRAIN_TX       = 4'd6,
    RETRAIN          = 4'd7,
    LINK_ERR_TX      = 4'd8,
    LINK_RST_TX      = 4'd9,
    LINK_RESET       = 4'd10,
    LINK_ERROR       = 4'd11
  } phy_state_e;

  // Sideband opcodes exchanged with the remote die
  typedef enum logic [3:0] {
    SB_IDLE        = 4'd0,
    SB_ACT_REQ     = 4'd1,
    SB_ACT_RSP     = 4'd2,
    SB_RETRAIN_REQ = 4'd3,
    SB_RETRAIN_RSP = 4'd4,
    SB_LNKERR_REQ  = 4'd5,
    SB_LNKERR_RSP  = 4'd6,
    SB_LNKRST_REQ  = 4'd7,
    SB_LNKRST_RSP  = 4'd8
  } sb_msg_e;

  // Adapter state codes, for both requests and status
  typedef enum logic [3:0] {
    RDI_RESET     = 4'd0,
    RDI_ACTIVE    = 4'd1,
    RDI_LINKRESET = 4'd9,
    RDI_LINKERROR = 4'd10,
    RDI_RETRAIN   = 4'd11
  } rdi_state_e;

  // Cycles spent in LINK_TRAINING or RETRAIN
  localparam int TRAIN_CYCLES = 4;
  // Cycles in a remotely caused LINK_ERROR or LINK_RESET
  localparam int TIMEOUT_CYCLES = 4;
  localparam int CNT_W = 3;

endpackage

// ==== test/tb_ucie_phy_ctl.sv ====
`timescale 1ns/100ps

module tb_ucie_phy_ctl;
  import ucie_phy_pkg::*;

  logic        i_clk;
  logic        i_rst_n;
  logic [3:0]  i_lp_state_req;
  logic        i_lp_linkerror;
  logic [3:0]  i_sb_msg_in;
  logic        i_start_link_training;
  logic        i_phy_trainerror;
  logic        i_phy_pl_error;
  logic [3:0]  o_pl_state_sts;
  logic        o_pl_phyinrecenter;
  logic        o_pl_inband_pres;
  logic        o_rdi_enable;
  logic [3:0]  o_sb_msg_out;

  phy_state_e  m_state;
  phy_state_e  m_nxt;
  int          m_cyc;
  logic        m_err_flag;
  logic        m_rst_flag;
  logic [10:0] m_row;
  int          errors = 0;
  int          timeouts = 0;
  int          n;
  integer      seed = 32'h6ef1_60ce;
  logic [31:0] r;
  string       test_name = "reset";

  ucie_phy_ctl UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Reference model of the next link state from the sampled inputs
  function automatic phy_state_e next_state(phy_state_e s, int cyc, logic ef, logic rf);
    logic el;
    logic la;
    el = i_lp_linkerror | i_phy_trainerror;
    la = (i_lp_state_req == RDI_ACTIVE);
    next_state = s;
    if (s == LINK_ERR_TX || s == LINK_RST_TX) begin
      if (i_sb_msg_in == SB_LNKERR_RSP)
        next_state = LINK_ERROR;
      else if (s == LINK_RST_TX && i_sb_msg_in == SB_LNKRST_RSP)
        next_state = LINK_RESET;
    end else if (s == LINK_ERROR) begin
      if (ef ? la : cyc >= TIMEOUT_CYCLES)
        next_state = RESET;
    end else if (el) begin
      next_state = LINK_ERR_TX;
    end else if (i_sb_msg_in == SB_LNKERR_REQ) begin
      next_state = LINK_ERROR;
    end else if (s == LINK_RESET) begin
      if (rf ? la : cyc >= TIMEOUT_CYCLES)
        next_state = RESET;
    end else if (i_lp_state_req == RDI_LINKRESET) begin
      next_state = LINK_RST_TX;
    end else if (i_sb_msg_in == SB_LNKRST_REQ) begin
      next_state = LINK_RESET;
    end else begin
      case (s)
        RESET:
          if (i_start_link_training)
            next_state = LINK_TRAINING;
        LINK_TRAINING, RETRAIN:
          if (cyc >= TRAIN_CYCLES)
            next_state = WAIT_FOR_ADAPTER;
        WAIT_FOR_ADAPTER:
          if (i_sb_msg_in == SB_ACT_REQ)
            next_state = (ef || rf) ? ACTIVE : RSP_ACTIVE;
          else if (!ef && !rf && la)
            next_state = REQ_ACTIVE;
        REQ_ACTIVE:
          if (i_sb_msg_in == SB_ACT_RSP)
            next_state = ACTIVE;
        RSP_ACTIVE:
          if (la)
            next_state = ACTIVE;
        ACTIVE:
          if (i_lp_state_req == RDI_RETRAIN)
            next_state = RETRAIN_TX;
          else if (i_phy_pl_error || i_sb_msg_in == SB_RETRAIN_REQ)
            next_state = RETRAIN;
        RETRAIN_TX:
          if (i_sb_msg_in == SB_RETRAIN_RSP)
            next_state = RETRAIN;
        default: ;
      endcase
    end
  endfunction

  // Row is status, recenter, inband, enable, sideband
  function automatic logic [10:0] expected_row(phy_state_e s);
    case (s)
      LINK_TRAINING:    return {RDI_RESET, 3'b100, SB_IDLE};
      WAIT_FOR_ADAPTER: return {RDI_RESET, 3'b010, SB_IDLE};
      REQ_ACTIVE:       return {RDI_RESET, 3'b010, SB_ACT_REQ};
      RSP_ACTIVE:       return {RDI_RESET, 3'b010, SB_IDLE};
      ACTIVE:           return {RDI_ACTIVE, 3'b011, SB_ACT_RSP};
      RETRAIN_TX:       return {RDI_ACTIVE, 3'b011, SB_RETRAIN_REQ};
      RETRAIN:          return {RDI_RETRAIN, 3'b100, SB_IDLE};
      LINK_ERR_TX:      return {RDI_ACTIVE, 3'b001, SB_LNKERR_REQ};
      LINK_RST_TX:      return {RDI_ACTIVE, 3'b001, SB_LNKRST_REQ};
      LINK_RESET:       return {RDI_LINKRESET, 3'b000, SB_LNKRST_RSP};
      LINK_ERROR:       return {RDI_LINKERROR, 3'b000, SB_LNKERR_RSP};
      default:          return {RDI_RESET, 3'b000, SB_IDLE};
    endcase
  endfunction

  function automatic logic [10:0] out_row();
    return {o_pl_state_sts, o_pl_phyinrecenter, o_pl_inband_pres, o_rdi_enable, o_sb_msg_out};
  endfunction

  task automatic check_state_sts(string name, rdi_state_e exp, rdi_state_e act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: status expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_sb_msg(string name, sb_msg_e exp, sb_msg_e act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: sideband expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      errors++;
      $display("Fail %s: expected %0d cycles actual %0d", name, exp, act);
    end
  endtask

  // Model step and output compare on every rising edge
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      m_state    = RESET;
      m_cyc      = 1;
      m_err_flag = 1'b0;
      m_rst_flag = 1'b0;
    end else begin
      m_nxt = next_state(m_state, m_cyc, m_err_flag, m_rst_flag);
      if (m_state == ACTIVE) begin
        m_err_flag = 1'b0;
        m_rst_flag = 1'b0;
      end else if (i_lp_linkerror || i_phy_trainerror)
        m_err_flag = 1'b1;
      else if (i_lp_state_req == RDI_LINKRESET)
        m_rst_flag = 1'b1;
      m_cyc   = (m_nxt == m_state) ? m_cyc + 1 : 1;
      m_state = m_nxt;
    end
    #1;
    m_row = expected_row(m_state);
    check_state_sts(test_name, rdi_state_e'(m_row[10:7]), rdi_state_e'(o_pl_state_sts));
    check_bit({test_name, " recenter"}, m_row[6], o_pl_phyinrecenter);
    check_bit({test_name, " inband"}, m_row[5], o_pl_inband_pres);
    check_bit({test_name, " enable"}, m_row[4], o_rdi_enable);
    check_sb_msg(test_name, sb_msg_e'(m_row[3:0]), sb_msg_e'(o_sb_msg_out));
  end

  task automatic wait_state(phy_state_e s);
    int k = 0;
    while (out_row() !== expected_row(s) && k < 40) begin
      @(negedge i_clk);
      k++;
    end
    if (out_row() !== expected_row(s)) begin
      timeouts++;
      $display("Timeout in %s: outputs never showed state %s", test_name, s.name());
    end
  endtask

  // Cycles for which the outputs stay on the row of one state
  task automatic count_state(phy_state_e s, output int cnt);
    cnt = 0;
    while (out_row() === expected_row(s) && cnt < 40) begin
      @(negedge i_clk);
      cnt++;
    end
  endtask

  task automatic pulse_sb(sb_msg_e m);
    i_sb_msg_in = m;
    @(negedge i_clk);
    i_sb_msg_in = SB_IDLE;
  endtask

  task automatic train();
    int cnt;
    i_start_link_training = 1'b1;
    @(negedge i_clk);
    i_start_link_training = 1'b0;
    count_state(LINK_TRAINING, cnt);
    check_count({test_name, " training"}, TRAIN_CYCLES, cnt);
  endtask

  task automatic bring_up_remote();
    pulse_sb(SB_ACT_REQ);
    i_lp_state_req = RDI_ACTIVE;
    wait_state(ACTIVE);
    i_lp_state_req = RDI_RESET;
  endtask

  initial begin
    i_rst_n               = 1'b0;
    i_lp_state_req        = RDI_RESET;
    i_lp_linkerror        = 1'b0;
    i_sb_msg_in           = SB_IDLE;
    i_start_link_training = 1'b0;
    i_phy_trainerror      = 1'b0;
    i_phy_pl_error        = 1'b0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;

    test_name = "local bring-up";
    train();
    i_lp_state_req = RDI_ACTIVE;
    wait_state(REQ_ACTIVE);
    i_lp_state_req = RDI_RESET;
    pulse_sb(SB_ACT_RSP);
    check_bit("local bring-up enable", 1'b1, o_rdi_enable);

    test_name = "local retrain";
    i_lp_state_req = RDI_RETRAIN;
    wait_state(RETRAIN_TX);
    i_lp_state_req = RDI_RESET;
    pulse_sb(SB_RETRAIN_RSP);
    count_state(RETRAIN, n);
    check_count("local retrain length", TRAIN_CYCLES, n);
    check_bit("local retrain inband", 1'b1, o_pl_inband_pres);

    test_name = "remote bring-up";
    bring_up_remote();

    test_name = "pl error retrain";
    i_phy_pl_error = 1'b1;
    @(negedge i_clk);
    i_phy_pl_error = 1'b0;
    count_state(RETRAIN, n);
    check_count("pl error retrain length", TRAIN_CYCLES, n);
    bring_up_remote();

    // Error held for a second edge so the local origin is recorded
    test_name = "local link error";
    i_lp_linkerror = 1'b1;
    wait_state(LINK_ERR_TX);
    @(negedge i_clk);
    i_lp_linkerror = 1'b0;
    pulse_sb(SB_LNKERR_RSP);
    repeat (TIMEOUT_CYCLES + 2) @(negedge i_clk);
    check_state_sts("local link error hold", RDI_LINKERROR, rdi_state_e'(o_pl_state_sts));
    i_lp_state_req = RDI_ACTIVE;
    wait_state(RESET);
    i_lp_state_req = RDI_RESET;
    train();
    bring_up_remote();

    test_name = "remote link error";
    pulse_sb(SB_LNKERR_REQ);
    count_state(LINK_ERROR, n);
    check_count("remote link error timeout", TIMEOUT_CYCLES, n);
    train();
    bring_up_remote();

    test_name = "local link reset";
    i_lp_state_req = RDI_LINKRESET;
    wait_state(LINK_RST_TX);
    @(negedge i_clk);
    i_lp_state_req = RDI_RESET;
    pulse_sb(SB_LNKRST_RSP);
    repeat (TIMEOUT_CYCLES + 2) @(negedge i_clk);
    check_state_sts("local link reset hold", RDI_LINKRESET, rdi_state_e'(o_pl_state_sts));
    test_name = "error in link reset";
    pulse_sb(SB_LNKERR_REQ);
    count_state(LINK_ERROR, n);
    check_count("error in link reset timeout", TIMEOUT_CYCLES, n);
    train();
    bring_up_remote();

    test_name = "remote link reset";
    pulse_sb(SB_LNKRST_REQ);
    count_state(LINK_RESET, n);
    check_count("remote link reset timeout", TIMEOUT_CYCLES, n);

    test_name = "random";
    repeat (4000) begin
      r = $random(seed);
      i_start_link_training = (r[2:0] == 3'd0);
      i_lp_linkerror        = (r[8:3] == 6'd0);
      i_phy_trainerror      = (r[15:9] == 7'd0);
      i_phy_pl_error        = (r[19:16] == 4'd0);
      case (r[23:20])
        4'd0: i_lp_state_req = RDI_LINKRESET;
        4'd1, 4'd2: i_lp_state_req = RDI_RETRAIN;
        4'd3, 4'd4, 4'd5, 4'd6: i_lp_state_req = RDI_ACTIVE;
        default: i_lp_state_req = RDI_RESET;
      endcase
      i_sb_msg_in = (r[25:24] == 2'd0) ? r[29:26] : SB_IDLE;
      @(negedge i_clk);
    end

    i_start_link_training = 1'b0;
    i_lp_linkerror        = 1'b0;
    i_phy_trainerror      = 1'b0;
    i_phy_pl_error        = 1'b0;
    i_lp_state_req        = RDI_RESET;
    i_sb_msg_in           = SB_IDLE;
    repeat (3) @(negedge i_clk);
    $display("Errors: %0d, timeouts: %0d, assertion failures: %0d", errors, timeouts,
             UUT.u_asserts.fail_cnt);
    if (errors == 0 && timeouts == 0 && UUT.u_asserts.fail_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== test/ucie_phy_ctl_asserts.sv ====
`timescale 1ns/100ps

module ucie_phy_ctl_asserts (
  input logic       i_clk,
  input logic       i_rst_n,
  input logic [3:0] i_state_sts,
  input logic       i_recenter,
  input logic       i_inband,
  input logic       i_enable,
  input logic [3:0] i_sb_msg
);
  import ucie_phy_pkg::*;

  int fail_cnt = 0;

  // Enable only while the adapter sees ACTIVE
  a_enable_active: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_enable |-> i_state_sts == RDI_ACTIVE)
    else begin
      fail_cnt++;
      $error("rdi enable high with status %0d", i_state_sts);
    end

  a_recenter_inband: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_recenter && i_inband))
    else begin
      fail_cnt++;
      $error("recenter and inband present high together");
    end

  a_legal_msg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_sb_msg <= SB_LNKRST_RSP)
    else begin
      fail_cnt++;
      $error("illegal sideband opcode %0d", i_sb_msg);
    end

  a_reset_idle: assert property (@(posedge i_clk)
    !i_rst_n |-> (i_state_sts == RDI_RESET) && !i_recenter && !i_inband && !i_enable
      && (i_sb_msg == SB_IDLE))
    else begin
      fail_cnt++;
      $error("outputs active during reset");
    end

endmodule

bind ucie_phy_ctl ucie_phy_ctl_asserts u_asserts (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_state_sts (o_pl_state_sts),
  .i_recenter  (o_pl_phyinrecenter),
  .i_inband    (o_pl_inband_pres),
  .i_enable    (o_rdi_enable),
  .i_sb_msg    (o_sb_msg_out)
);
